// File: include/mem_req_defines.svh
/*
 * Width and depth macros for the memory request shim.
 * Covers the address, tag and line data widths, plus the
 * depth and almost-full threshold of the per-channel FIFOs.
 */

`ifndef MEM_REQ_DEFINES_SVH
`define MEM_REQ_DEFINES_SVH

// Width of one line address
`define MEM_ADDR_WIDTH 32

// Width of the per-channel sequence tag
`define MEM_TAG_WIDTH 8

// Width of the write line data
`define MEM_DATA_WIDTH 64

// Slots in each channel FIFO
`define REQ_FIFO_ENTRIES 6

// Almost-full rises once this many slots or fewer remain free
`define REQ_FIFO_THRESHOLD 4

`endif

// File: hw/mem_req_pkg.sv
/*
 * Payload types of the memory request path.
 * Holds the address, tag and line data vectors and the
 * occupancy counter type of the channel FIFOs.
 */

`default_nettype none

`include "mem_req_defines.svh"

package mem_req_pkg;

    // Line address of a request
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Sequence tag stamped on each request by the ingress stage
    typedef logic [`MEM_TAG_WIDTH-1:0] mem_tag_t;

    // Line data carried by a write
    typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

    // One extra bit so that a completely full FIFO can be counted
    typedef logic [$clog2(`REQ_FIFO_ENTRIES + 1)-1:0] fifo_cnt_t;

endpackage

`default_nettype wire

// File: hw/arb_pkg.sv
/*
 * Arbitration types for the memory port.
 * Holds the round-robin state and the channel identifier.
 */

`default_nettype none

package arb_pkg;

    // Records which channel won the most recent transfer
    typedef enum logic {
        LAST_RD = 1'b0,
        LAST_WR = 1'b1
    } arb_state_t;

    // Channel 0 carries reads and channel 1 carries writes
    typedef enum logic {
        CHAN_RD = 1'b0,
        CHAN_WR = 1'b1
    } chan_id_t;

endpackage

`default_nettype wire

// File: hw/req_chan_if.sv
/*
 * Two-channel request bundle.
 * Carries the read channel, the write channel with its line data,
 * and the almost-full flag of each channel flowing back.
 * Modports for the sending and the receiving side.
 */

`timescale 1ns/1ps
`default_nettype none

interface req_chan_if
    import mem_req_pkg::*;
();

    // Channel 0, reads
    logic      rd_valid;
    mem_addr_t rd_addr;
    mem_tag_t  rd_tag;

    // Channel 1, writes with a full line of data
    logic      wr_valid;
    mem_addr_t wr_addr;
    mem_tag_t  wr_tag;
    mem_data_t wr_data;

    // Flow control back toward the sender, one flag per channel
    logic      rd_alm_full;
    logic      wr_alm_full;

    modport sender (
        output rd_valid, rd_addr, rd_tag,
        output wr_valid, wr_addr, wr_tag, wr_data,
        input  rd_alm_full, wr_alm_full
    );

    modport receiver (
        input  rd_valid, rd_addr, rd_tag,
        input  wr_valid, wr_addr, wr_tag, wr_data,
        output rd_alm_full, wr_alm_full
    );

endinterface

`default_nettype wire

// File: hw/req_ingress.sv
/*
 * Ingress register stage of the request shim.
 * Registers each incoming read and write request and stamps it
 * with that channel's sequence tag. The buffer's almost-full
 * flags are handed back out unchanged.
 */

`timescale 1ns/1ps
`default_nettype none

module req_ingress
    import mem_req_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      in_rd_valid,
    input  mem_addr_t in_rd_addr,
    input  logic      in_wr_valid,
    input  mem_addr_t in_wr_addr,
    input  mem_data_t in_wr_data,

    output logic      out_rd_alm_full,
    output logic      out_wr_alm_full,

    req_chan_if.sender req
);

    // Next tag to hand out on each channel
    mem_tag_t rd_tag_cnt;
    mem_tag_t wr_tag_cnt;

    // ====================
    // Control state
    // ====================

    // Valids and tag counters are the only state that needs a reset.
    // The counters wrap at the tag width, matching the modulo tag seen downstream
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req.rd_valid <= 1'b0;
            req.wr_valid <= 1'b0;
            rd_tag_cnt   <= '0;
            wr_tag_cnt   <= '0;
        end
        else
        begin
            req.rd_valid <= in_rd_valid;
            req.wr_valid <= in_wr_valid;
            if (in_rd_valid)
                rd_tag_cnt <= rd_tag_cnt + 1'b1;
            if (in_wr_valid)
                wr_tag_cnt <= wr_tag_cnt + 1'b1;
        end
    end

    // ====================
    // Payload registers
    // ====================

    // Payload is only meaningful while the matching valid is high
    always_ff @(posedge clk)
    begin
        req.rd_addr <= in_rd_addr;
        req.rd_tag  <= rd_tag_cnt;
        req.wr_addr <= in_wr_addr;
        req.wr_tag  <= wr_tag_cnt;
        req.wr_data <= in_wr_data;
    end

    // The flags are already registered inside the FIFOs
    assign out_rd_alm_full = req.rd_alm_full;
    assign out_wr_alm_full = req.wr_alm_full;

endmodule

`default_nettype wire

// File: hw/req_fifo_lutram.sv
/*
 * Small FIFO held in distributed RAM.
 * Circular buffer with read and write pointers and an occupancy count.
 * The head is shown first-word-out and almost-full is registered.
 */

`timescale 1ns/1ps
`default_nettype none

`include "mem_req_defines.svh"

module req_fifo_lutram
    import mem_req_pkg::*;
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = `REQ_FIFO_ENTRIES,
    parameter int THRESHOLD   = `REQ_FIFO_THRESHOLD
)
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   alm_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // Storage has no reset, only the pointers and the count do
    logic [N_DATA_BITS-1:0] ram [N_ENTRIES];

    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    fifo_cnt_t cnt;
    fifo_cnt_t cnt_next;
    logic      do_enq;
    logic      do_deq;

    // Depth need not be a power of two, so wrap explicitly
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_inc = (p == ptr_t'(N_ENTRIES - 1)) ? '0 : ptr_t'(p + 1'b1);
    endfunction

    assign not_empty = (cnt != '0);

    // A dequeue of an empty FIFO is ignored
    assign do_deq = deq_en && not_empty;

    // When full, an enqueue only fits alongside a dequeue
    assign do_enq = enq_en && ((cnt != fifo_cnt_t'(N_ENTRIES)) || do_deq);

    always_comb
    begin
        cnt_next = cnt;
        if (do_enq && !do_deq)
            cnt_next = cnt + 1'b1;
        else if (do_deq && !do_enq)
            cnt_next = cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (do_enq)
            ram[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            alm_full <= 1'b0;
        end
        else
        begin
            if (do_enq)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_deq)
                rd_ptr <= ptr_inc(rd_ptr);
            cnt <= cnt_next;
            // Flag follows the occupancy left after this cycle's traffic
            alm_full <= (cnt_next >= fifo_cnt_t'(N_ENTRIES - THRESHOLD));
        end
    end

    // First-word-out, the head is visible the cycle after its enqueue
    assign first = ram[rd_ptr];

endmodule

`default_nettype wire

// File: hw/req_buffer.sv
/*
 * Two-channel request buffer.
 * Holds each channel in its own FIFO and raises a per-channel
 * almost-full flag. Heads leave only on an explicit dequeue.
 * Reads may optionally skip an empty FIFO.
 */

`timescale 1ns/1ps
`default_nettype none

`include "mem_req_defines.svh"

module req_buffer
    import mem_req_pkg::*;
#(
    // Nonzero lets a read reach the head in the cycle it arrives
    // when the read FIFO is empty. Writes never bypass, as the
    // mux on the line data would cost too much
    parameter bit ENABLE_RD_BYPASS = 1'b0
)
(
    input  logic clk,
    input  logic rst,

    // Registered requests from the ingress stage
    req_chan_if.receiver raw,

    // Buffered heads, where a valid means a head is present
    req_chan_if.sender   buffered,

    // Consumer removes a head by pulsing the matching dequeue
    input  logic deq_rd,
    input  logic deq_wr
);

    localparam int RD_BITS = $bits(mem_addr_t) + $bits(mem_tag_t);
    localparam int WR_BITS = RD_BITS + $bits(mem_data_t);

    logic [RD_BITS-1:0] rd_first;
    logic               rd_not_empty;
    logic               rd_enq;
    logic               rd_deq;
    mem_addr_t          rd_fifo_addr;
    mem_tag_t           rd_fifo_tag;

    logic [WR_BITS-1:0] wr_first;
    logic               wr_not_empty;

    // ====================
    // Read channel
    // ====================

    // Field order here must match the enq_data packing below
    assign {rd_fifo_addr, rd_fifo_tag} = rd_first;

    generate
        if (ENABLE_RD_BYPASS == 1'b0)
        begin : g_no_bypass
            // Every read passes through the FIFO
            assign buffered.rd_valid = rd_not_empty;
            assign buffered.rd_addr  = rd_fifo_addr;
            assign buffered.rd_tag   = rd_fifo_tag;
            assign rd_enq            = raw.rd_valid;
            assign rd_deq            = deq_rd;
        end
        else
        begin : g_bypass
            // An empty FIFO lets the arriving read show through as the head
            assign buffered.rd_valid = rd_not_empty || raw.rd_valid;
            assign buffered.rd_addr  = rd_not_empty ? rd_fifo_addr : raw.rd_addr;
            assign buffered.rd_tag   = rd_not_empty ? rd_fifo_tag : raw.rd_tag;

            // Store the arriving read unless it was consumed straight away
            assign rd_enq = raw.rd_valid && (rd_not_empty || !deq_rd);
            assign rd_deq = deq_rd && rd_not_empty;
        end
    endgenerate

    req_fifo_lutram #(
        .N_DATA_BITS (RD_BITS),
        .N_ENTRIES   (`REQ_FIFO_ENTRIES),
        .THRESHOLD   (`REQ_FIFO_THRESHOLD)
    ) rd_fifo (
        .clk       (clk),
        .rst       (rst),
        .enq_data  ({raw.rd_addr, raw.rd_tag}),
        .enq_en    (rd_enq),
        .alm_full  (raw.rd_alm_full),
        .first     (rd_first),
        .deq_en    (rd_deq),
        .not_empty (rd_not_empty)
    );

    // ====================
    // Write channel
    // ====================

    // Unpack the head, same field order as the packing into the FIFO
    assign {buffered.wr_addr, buffered.wr_tag, buffered.wr_data} = wr_first;
    assign buffered.wr_valid = wr_not_empty;

    req_fifo_lutram #(
        .N_DATA_BITS (WR_BITS),
        .N_ENTRIES   (`REQ_FIFO_ENTRIES),
        .THRESHOLD   (`REQ_FIFO_THRESHOLD)
    ) wr_fifo (
        .clk       (clk),
        .rst       (rst),
        .enq_data  ({raw.wr_addr, raw.wr_tag, raw.wr_data}),
        .enq_en    (raw.wr_valid),
        .alm_full  (raw.wr_alm_full),
        .first     (wr_first),
        .deq_en    (deq_wr),
        .not_empty (wr_not_empty)
    );

endmodule

`default_nettype wire

// File: hw/req_arbiter.sv
/*
 * Round-robin arbiter onto the memory request port.
 * Picks between the buffered read and write heads, holds the
 * choice while the port stalls and dequeues the winner on transfer.
 */

`timescale 1ns/1ps
`default_nettype none

module req_arbiter
    import mem_req_pkg::*;
    import arb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Buffered heads from the request buffer
    req_chan_if.receiver heads,

    output logic      deq_rd,
    output logic      deq_wr,

    // Memory request port with a valid/ready handshake
    output logic      mem_valid,
    input  logic      mem_ready,
    output logic      mem_is_wr,
    output mem_addr_t mem_addr,
    output mem_tag_t  mem_tag,
    output mem_data_t mem_data
);

    arb_state_t state;
    chan_id_t   grant;
    chan_id_t   held_chan;
    logic       held;
    logic       xfer;

    // Flow control is carried by the dequeues on this link
    assign heads.rd_alm_full = 1'b0;
    assign heads.wr_alm_full = 1'b0;

    // ====================
    // Grant selection
    // ====================

    always_comb
    begin
        if (held)
            // A stalled offer keeps its channel so the payload stays put
            grant = held_chan;
        else if (heads.rd_valid && heads.wr_valid)
            // Both waiting, so the loser of the last transfer goes next
            grant = (state == LAST_RD) ? CHAN_WR : CHAN_RD;
        else if (heads.rd_valid)
            grant = CHAN_RD;
        else
            grant = CHAN_WR;
    end

    assign mem_valid = heads.rd_valid || heads.wr_valid;
    assign xfer      = mem_valid && mem_ready;

    // Dequeue lands in the same cycle as the transfer
    assign deq_rd = xfer && (grant == CHAN_RD);
    assign deq_wr = xfer && (grant == CHAN_WR);

    // ====================
    // Payload mux
    // ====================

    assign mem_is_wr = (grant == CHAN_WR);
    assign mem_addr  = (grant == CHAN_WR) ? heads.wr_addr : heads.rd_addr;
    assign mem_tag   = (grant == CHAN_WR) ? heads.wr_tag : heads.rd_tag;
    // Reads carry no data
    assign mem_data  = (grant == CHAN_WR) ? heads.wr_data : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Reads win the first tie
            state     <= LAST_WR;
            held      <= 1'b0;
            held_chan <= CHAN_RD;
        end
        else
        begin
            held      <= mem_valid && !mem_ready;
            held_chan <= grant;
            if (xfer)
                state <= (grant == CHAN_WR) ? LAST_WR : LAST_RD;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_req_top.sv
/*
 * Top level of the memory request shim.
 * Chains the ingress stage, the two-channel buffer and the
 * round-robin arbiter behind plain ports.
 */

`timescale 1ns/1ps
`default_nettype none

module mem_req_top
    import mem_req_pkg::*;
#(
    parameter bit ENABLE_RD_BYPASS = 1'b0
)
(
    input  logic      clk,
    input  logic      rst,

    // Request inputs, a one-cycle valid is one request
    input  logic      in_rd_valid,
    input  mem_addr_t in_rd_addr,
    input  logic      in_wr_valid,
    input  mem_addr_t in_wr_addr,
    input  mem_data_t in_wr_data,

    // Source may send on a channel only if its flag was low last cycle
    output logic      rd_alm_full,
    output logic      wr_alm_full,

    output logic      mem_valid,
    input  logic      mem_ready,
    output logic      mem_is_wr,
    output mem_addr_t mem_addr,
    output mem_tag_t  mem_tag,
    output mem_data_t mem_data
);

    logic deq_rd;
    logic deq_wr;

    req_chan_if ingress_to_buf ();
    req_chan_if buf_to_arb ();

    req_ingress ingress_i (
        .clk             (clk),
        .rst             (rst),
        .in_rd_valid     (in_rd_valid),
        .in_rd_addr      (in_rd_addr),
        .in_wr_valid     (in_wr_valid),
        .in_wr_addr      (in_wr_addr),
        .in_wr_data      (in_wr_data),
        .out_rd_alm_full (rd_alm_full),
        .out_wr_alm_full (wr_alm_full),
        .req             (ingress_to_buf.sender)
    );

    req_buffer #(
        .ENABLE_RD_BYPASS (ENABLE_RD_BYPASS)
    ) buffer_i (
        .clk      (clk),
        .rst      (rst),
        .raw      (ingress_to_buf.receiver),
        .buffered (buf_to_arb.sender),
        .deq_rd   (deq_rd),
        .deq_wr   (deq_wr)
    );

    req_arbiter arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .heads     (buf_to_arb.receiver),
        .deq_rd    (deq_rd),
        .deq_wr    (deq_wr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_is_wr (mem_is_wr),
        .mem_addr  (mem_addr),
        .mem_tag   (mem_tag),
        .mem_data  (mem_data)
    );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 * 20 ns clock, reset held high for the first two rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Released just after the second edge, like the rest of the stimulus
    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/tb_mem_req.sv
/*
 * Testbench for the memory request shim.
 * Drives reads and writes into the top level, keeps a reference
 * queue per channel and compares every memory port transfer.
 * Tracks the expected almost-full flags from the queue occupancy.
 * Covers in-order delivery, stalls, back-pressure and fairness.
 */

`timescale 1ns/1ps
`default_nettype none

`include "mem_req_defines.svh"

module tb_mem_req
    import mem_req_pkg::*;
    import arb_pkg::*;
();

    // Stimulus length of each test in cycles. The drains add a few cycles each
    localparam int T1_CYCLES = 40;
    localparam int T2_CYCLES = 60;
    localparam int T3_CYCLES = 160;
    localparam int T4_CYCLES = 12;
    localparam int T5_CYCLES = 8;
    // Idle cycles after a drain in which a leftover offer would show up
    localparam int SETTLE_CYCLES = 4;
    // Roughly 300 stimulus cycles leave a wide margin below this limit
    localparam int CYCLE_LIMIT = 4000;

    typedef struct packed {
        mem_addr_t addr;
        mem_tag_t  tag;
        mem_data_t data;
    } exp_req_t;

    logic      clk;
    logic      rst;
    logic      in_rd_valid;
    mem_addr_t in_rd_addr;
    logic      in_wr_valid;
    mem_addr_t in_wr_addr;
    mem_data_t in_wr_data;
    logic      rd_alm_full;
    logic      wr_alm_full;
    logic      mem_valid;
    logic      mem_ready;
    logic      mem_is_wr;
    mem_addr_t mem_addr;
    mem_tag_t  mem_tag;
    mem_data_t mem_data;

    // Requests sent but not yet seen on the memory port
    exp_req_t  rd_q[$];
    exp_req_t  wr_q[$];

    int        seed;
    int        rd_sent;
    int        wr_sent;
    int        rd_recv;
    int        wr_recv;
    int        err_count;
    int        tests_passed;
    int        tests_failed;
    int        cycle_count;

    // Flags as seen in the previous cycle gate the source
    logic      rd_af_prev;
    logic      wr_af_prev;
    logic      rd_af_seen;
    logic      wr_af_seen;

    // Valids driven in the previous cycle are still in the ingress register
    logic      rd_in_prev;
    logic      wr_in_prev;

    // The last offer made while mem_ready was low must stay put
    logic      stalled;
    logic      stall_is_wr;
    mem_addr_t stall_addr;
    mem_tag_t  stall_tag;
    mem_data_t stall_data;

    // Round-robin tracking is only active during the fairness test
    logic      fair_mode;
    int        fair_count;
    logic      fair_last_wr;

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    mem_req_top mem_req_top_i (
        .clk         (clk),
        .rst         (rst),
        .in_rd_valid (in_rd_valid),
        .in_rd_addr  (in_rd_addr),
        .in_wr_valid (in_wr_valid),
        .in_wr_addr  (in_wr_addr),
        .in_wr_data  (in_wr_data),
        .rd_alm_full (rd_alm_full),
        .wr_alm_full (wr_alm_full),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_is_wr   (mem_is_wr),
        .mem_addr    (mem_addr),
        .mem_tag     (mem_tag),
        .mem_data    (mem_data)
    );

    // ====================
    // Reference model
    // ====================

    // Request number idx of a channel carries the request count mod 256 as its tag
    function automatic exp_req_t expected_req(input chan_id_t chan, input int idx);
        exp_req_t e;
        e.tag = mem_tag_t'(idx % 256);
        if (chan == CHAN_RD)
        begin
            e.addr = mem_addr_t'(32'h0010_0000 + idx * 64);
            // Reads leave the memory port with zero data
            e.data = '0;
        end
        else
        begin
            e.addr = mem_addr_t'(32'h8000_0000 + idx * 32'h0000_0a40);
            e.data = mem_data_t'({~e.addr, e.addr ^ mem_addr_t'(idx * 7)});
        end
        return e;
    endfunction

    // Flag after the last rising edge, from the requests that reached the FIFO
    function automatic logic expected_alm_full(input int queued, input logic in_now,
                                               input logic in_last);
        int occupancy;
        // Requests on the inputs or in the ingress register are not in the FIFO yet
        occupancy = queued - int'(in_now) - int'(in_last);
        return (`REQ_FIFO_ENTRIES - occupancy) <= `REQ_FIFO_THRESHOLD;
    endfunction

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic report_error(input string msg);
        $display("error at time %0d ns: %s", $time, msg);
        err_count++;
    endtask

    // ====================
    // Stimulus
    // ====================

    // One cycle of stimulus is applied shortly after the rising edge
    task automatic drive_cycle(input logic want_rd, input logic want_wr, input logic ready);
        exp_req_t e;
        @(posedge clk);
        #1;
        in_rd_valid = 1'b0;
        in_wr_valid = 1'b0;
        mem_ready   = ready;
        // A channel may only send if its flag was low in the previous cycle
        if (want_rd && !rd_af_prev)
        begin
            e = expected_req(CHAN_RD, rd_sent);
            in_rd_valid = 1'b1;
            in_rd_addr  = e.addr;
            rd_q.push_back(e);
            rd_sent++;
        end
        if (want_wr && !wr_af_prev)
        begin
            e = expected_req(CHAN_WR, wr_sent);
            in_wr_valid = 1'b1;
            in_wr_addr  = e.addr;
            in_wr_data  = e.data;
            wr_q.push_back(e);
            wr_sent++;
        end
    endtask

    // Lost requests keep this waiting until the cycle limit hits
    task automatic drain_requests();
        while (rd_q.size() > 0 || wr_q.size() > 0)
            drive_cycle(1'b0, 1'b0, 1'b1);
        // Any offer left now is a request that was never sent
        repeat (SETTLE_CYCLES) drive_cycle(1'b0, 1'b0, 1'b1);
    endtask

    task automatic check_counts();
        if (rd_recv != rd_sent || wr_recv != wr_sent)
            report_error($sformatf("transfer counts differ: reads %0d of %0d, writes %0d of %0d",
                                   rd_recv, rd_sent, wr_recv, wr_sent));
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            tests_passed++;
            $display("test %0d (%s) passed", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d (%s) failed with %0d errors", num, name,
                     err_count - errs_before);
        end
    endtask

    // ====================
    // Checking
    // ====================

    // Called at mid-cycle for a transfer that completes on the next edge
    task automatic check_transfer();
        exp_req_t e;
        if (fair_mode)
        begin
            if (fair_count == 0 && mem_is_wr)
                report_error("first grant after release went to the write channel");
            else if (fair_count > 0 && rd_q.size() > 0 && wr_q.size() > 0
                     && mem_is_wr == fair_last_wr)
                report_error("grants did not alternate while both channels were waiting");
            fair_last_wr = mem_is_wr;
            fair_count++;
        end
        // Every transfer counts, whether or not a request was outstanding
        if (mem_is_wr)
            wr_recv++;
        else
            rd_recv++;
        if (mem_is_wr && wr_q.size() == 0)
            report_error("write transfer with no write outstanding");
        else if (!mem_is_wr && rd_q.size() == 0)
            report_error("read transfer with no read outstanding");
        else
        begin
            if (mem_is_wr)
                e = wr_q.pop_front();
            else
                e = rd_q.pop_front();
            if (mem_addr !== e.addr || mem_tag !== e.tag || mem_data !== e.data)
                report_error($sformatf("%s mismatch: expected addr %h tag %h data %h, got %h %h %h",
                                       mem_is_wr ? "write" : "read", e.addr, e.tag, e.data,
                                       mem_addr, mem_tag, mem_data));
        end
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            stalled = 1'b0;
        end
        else
        begin
            if (rd_alm_full)
                rd_af_seen = 1'b1;
            if (wr_alm_full)
                wr_af_seen = 1'b1;
            // Queues still hold this cycle's transfer, which dequeues on the next edge
            if (rd_alm_full !== expected_alm_full(rd_q.size(), in_rd_valid, rd_in_prev))
                report_error($sformatf("read almost-full flag is %b, expected %b",
                                       rd_alm_full, !rd_alm_full));
            if (wr_alm_full !== expected_alm_full(wr_q.size(), in_wr_valid, wr_in_prev))
                report_error($sformatf("write almost-full flag is %b, expected %b",
                                       wr_alm_full, !wr_alm_full));
            // A stalled offer has to stay valid and unchanged
            if (stalled && (!mem_valid || mem_is_wr !== stall_is_wr || mem_addr !== stall_addr
                            || mem_tag !== stall_tag || mem_data !== stall_data))
                report_error("memory request changed while mem_ready was low");
            stalled     = mem_valid && !mem_ready;
            stall_is_wr = mem_is_wr;
            stall_addr  = mem_addr;
            stall_tag   = mem_tag;
            stall_data  = mem_data;
            if (mem_valid && mem_ready)
                check_transfer();
        end
        rd_af_prev = rd_alm_full;
        wr_af_prev = wr_alm_full;
        rd_in_prev = in_rd_valid;
        wr_in_prev = in_wr_valid;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run timed out after %0d cycles with requests still outstanding",
                     cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin : main_seq
        int errs;
        int sent_before;
        seed         = 61;
        in_rd_valid  = 1'b0;
        in_rd_addr   = '0;
        in_wr_valid  = 1'b0;
        in_wr_addr   = '0;
        in_wr_data   = '0;
        mem_ready    = 1'b0;
        rd_af_prev   = 1'b0;
        wr_af_prev   = 1'b0;
        rd_af_seen   = 1'b0;
        wr_af_seen   = 1'b0;
        rd_in_prev   = 1'b0;
        wr_in_prev   = 1'b0;
        stalled      = 1'b0;
        fair_mode    = 1'b0;
        fair_count   = 0;
        fair_last_wr = 1'b0;
        @(negedge rst);

        // Reads only with the port always ready
        errs = err_count;
        repeat (T1_CYCLES) drive_cycle(1'b1, 1'b0, 1'b1);
        drain_requests();
        check_counts();
        finish_test(1, "reads only", errs);

        // Writes only while the port stalls at random
        errs = err_count;
        repeat (T2_CYCLES) drive_cycle(1'b0, random_bit(), random_bit());
        drain_requests();
        check_counts();
        finish_test(2, "writes with random stalls", errs);

        // Mixed traffic on both channels
        errs = err_count;
        repeat (T3_CYCLES) drive_cycle(random_bit(), random_bit(), random_bit());
        drain_requests();
        check_counts();
        finish_test(3, "mixed random traffic", errs);

        // Fill both FIFOs against a stalled port
        errs = err_count;
        rd_af_seen = 1'b0;
        wr_af_seen = 1'b0;
        repeat (T4_CYCLES) drive_cycle(1'b1, 1'b1, 1'b0);
        if (!rd_af_seen || !wr_af_seen)
            report_error("almost-full never rose on both channels under back-pressure");
        drain_requests();
        check_counts();
        finish_test(4, "back-pressure", errs);

        // A lone write leaves the arbiter favouring reads on the next tie
        errs = err_count;
        drive_cycle(1'b0, 1'b1, 1'b1);
        drain_requests();
        sent_before = rd_sent + wr_sent;
        repeat (T5_CYCLES) drive_cycle(1'b1, 1'b1, 1'b0);
        repeat (3) drive_cycle(1'b0, 1'b0, 1'b0);
        fair_mode  = 1'b1;
        fair_count = 0;
        drain_requests();
        fair_mode = 1'b0;
        if (fair_count != rd_sent + wr_sent - sent_before)
            report_error("fairness release delivered a different number of requests than sent");
        check_counts();
        finish_test(5, "round-robin fairness", errs);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hw/mem_req_pkg.sv
hw/arb_pkg.sv
hw/req_chan_if.sv
hw/req_ingress.sv
hw/req_fifo_lutram.sv
hw/req_buffer.sv
hw/req_arbiter.sv
hw/mem_req_top.sv
test/tb_clk_gen.sv
test/tb_mem_req.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory request shim testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_mem_req -o tb_mem_req \
    && ./obj_dir/tb_mem_req | tee sim.log \
    || { echo "Build or run of the simulation failed"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not finish cleanly"; exit 1; }
echo "Simulation passed"
exit 0
